//--- sources.f
+incdir+include
hdl/mips_pkg.sv
hdl/mips_stage_if.sv
hdl/mips_decode.sv
hdl/mips_alu.sv
hdl/mips_writeback.sv
hdl/mips_top.sv
tb/mips_assertions.sv
tb/tb_mips.sv

//--- Makefile
# Verilator build and run of the MIPS execute path testbench
# the simulator exit status carries pass or fail

all: run

obj_dir/Vtb_mips: sources.f $(wildcard hdl/*.sv tb/*.sv include/*.svh)
	verilator --binary --timing --assert --top-module tb_mips -f sources.f -Mdir obj_dir

run: obj_dir/Vtb_mips
	./obj_dir/Vtb_mips

lint:
	verilator --lint-only --timing --assert --top-module tb_mips -f sources.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

//--- tb/mips_input.txt
# W instr(hex) dest(dec, - for no retire) data(hex), retire due two cycles after ack
# R reg(dec) value(hex), read back over Wishbone
W 3C018000 1 80000000
W 34210005 1 80000005
W 2402FFFD 2 FFFFFFFD
W 20030007 3 00000007
W 00232020 4 8000000C
W 00612822 5 80000002
W 00033023 6 FFFFFFF9
W 00423821 7 FFFFFFFA
W 00224024 8 80000005
W 00664825 9 FFFFFFFF
W 00225026 10 7FFFFFF8
W 00605827 11 FFFFFFF8
W 0023602A 12 00000001
W 0023682B 13 00000000
W 284EFFFE 14 00000001
W 2C6FFFFF 15 00000001
W 3050F0F0 16 0000F0F0
W 38318001 17 80008004
W 00039100 18 00000070
W 00019903 19 F8000000
W 0001A102 20 08000000
W 0061A804 21 00000280
W 0061B007 22 FF000000
W 0061B806 23 01000000
W 27180011 24 00000011
W 27180011 24 00000022
W 0318C020 24 00000044
W 24600100 0 00000107
W FF180000 - -
R 0 00000000
R 24 00000044
R 5 80000002
R 19 F8000000

//--- tb/tb_mips.sv
// --------------------------------------------------------------------------
// testbench for mips_top, Wishbone transfers come from tb/mips_input.txt
// run from the project root so the data file path resolves
// stops at the first error, a cycle counter bounds the run
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`include "mips_defs.svh"

module tb_mips;

   logic                       clk;
   logic                       rst_b;
   logic                       wb_cyc;
   logic                       wb_stb;
   logic                       wb_we;
   logic [`MIPS_REG_BITS-1:0]  wb_adr;
   logic [`MIPS_XLEN-1:0]      wb_dat_w;
   logic [`MIPS_XLEN-1:0]      wb_dat_r;
   logic                       wb_ack;
   logic                       res_valid;
   logic [`MIPS_REG_BITS-1:0]  res_reg;
   logic [`MIPS_XLEN-1:0]      res_data;

   // one entry per data file line
   bit                         line_we [$];
   // instruction word, or register number for a read
   logic [`MIPS_XLEN-1:0]      line_word [$];
   bit                         line_pulse [$];
   logic [`MIPS_REG_BITS-1:0]  line_reg [$];
   logic [`MIPS_XLEN-1:0]      line_data [$];

   // retire slots, in ack order
   int unsigned                exp_cycle [$];
   bit                         exp_pulse [$];
   logic [`MIPS_REG_BITS-1:0]  exp_reg [$];
   logic [`MIPS_XLEN-1:0]      exp_data [$];

   int unsigned                cycle_count = 0;
   int unsigned                cycle_limit = 0;

   mips_top dut0 (
      .clk       (clk),
      .rst_b     (rst_b),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_dat_w  (wb_dat_w),
      .wb_dat_r  (wb_dat_r),
      .wb_ack    (wb_ack),
      .res_valid (res_valid),
      .res_reg   (res_reg),
      .res_data  (res_data)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("Testbench failed");
      $fatal(1, "run stopped at the first error");
   endtask

   // parse every line up front, the timeout depends on the count
   task automatic read_stimulus();
      int          fd;
      int          n;
      int          num;
      string       line;
      string       kind;
      string       dest_s;
      logic [31:0] word;
      logic [31:0] data;

      fd = $fopen("tb/mips_input.txt", "r");
      if (fd == 0) begin
         fail_run("cannot open the stimulus file tb/mips_input.txt");
      end else begin
         while ($fgets(line, fd) != 0) begin
            // skip blank and comment lines
            if (line.len() < 2 || line[0] == "#") continue;
            n = $sscanf(line, "%s", kind);
            if (kind == "W") begin
               n = $sscanf(line, "%s %h %s %h", kind, word, dest_s, data);
               if (n < 3 || (dest_s != "-" && n != 4)) begin
                  fail_run({"malformed write line in the stimulus file: ", line});
               end
               num = (dest_s == "-") ? 0 : dest_s.atoi();
               line_we.push_back(1'b1);
               line_word.push_back(word);
               line_pulse.push_back(dest_s != "-");
               line_reg.push_back(num[4:0]);
               line_data.push_back((dest_s == "-") ? 32'h0 : data);
            end else if (kind == "R") begin
               n = $sscanf(line, "%s %d %h", kind, num, data);
               if (n != 3) begin
                  fail_run({"malformed read line in the stimulus file: ", line});
               end
               line_we.push_back(1'b0);
               line_word.push_back(num);
               line_pulse.push_back(1'b0);
               line_reg.push_back(num[4:0]);
               line_data.push_back(data);
            end else begin
               fail_run({"unknown line kind in the stimulus file: ", line});
            end
         end
         $fclose(fd);
      end
   endtask

   // called 2 ns after a rising edge, returns 2 ns after the edge ending ack
   task automatic run_transfer(input int i);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = line_we[i];
      wb_adr   = line_we[i] ? '0 : line_word[i][4:0];
      wb_dat_w = line_we[i] ? line_word[i] : '0;
      @(negedge clk);
      while (!wb_ack) @(negedge clk);
      if (line_we[i]) begin
         // retire slot two cycles after the ack cycle
         exp_cycle.push_back(cycle_count + 2);
         exp_pulse.push_back(line_pulse[i]);
         exp_reg.push_back(line_reg[i]);
         exp_data.push_back(line_data[i]);
      end else begin
         assert (wb_dat_r == line_data[i])
            else fail_run($sformatf("MISMATCH at %0t wb_dat_r reg %0d expected %h got %h",
                                    $time, line_reg[i], line_data[i], wb_dat_r));
      end
      @(posedge clk);
      #2;
   endtask

   // cycle counter and timeout
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
         fail_run($sformatf("timeout, run still busy after %0d cycles", cycle_count));
      end
   end

   // retire port, sampled mid-cycle
   always @(negedge clk) begin
      if (rst_b) begin
         if (exp_cycle.size() != 0 && exp_cycle[0] == cycle_count) begin
            if (exp_pulse[0]) begin
               assert (res_valid)
                  else fail_run($sformatf("MISMATCH at %0t res_valid expected 1 got %b",
                                          $time, res_valid));
               assert (res_reg == exp_reg[0])
                  else fail_run($sformatf("MISMATCH at %0t res_reg expected %0d got %0d",
                                          $time, exp_reg[0], res_reg));
               assert (res_data == exp_data[0])
                  else fail_run($sformatf("MISMATCH at %0t res_data expected %h got %h",
                                          $time, exp_data[0], res_data));
            end else begin
               // unknown opcode retires nothing
               assert (!res_valid)
                  else fail_run($sformatf("MISMATCH at %0t res_valid expected 0 got %b",
                                          $time, res_valid));
            end
            void'(exp_cycle.pop_front());
            void'(exp_pulse.pop_front());
            void'(exp_reg.pop_front());
            void'(exp_data.pop_front());
         end else begin
            assert (!res_valid)
               else fail_run($sformatf("MISMATCH at %0t res_valid expected 0 got %b",
                                       $time, res_valid));
         end
      end
   end

   initial begin
      int gap;

      rst_b    = 1'b0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      void'($urandom(32'h9d47_fb13));
      read_stimulus();
      // reset plus at most 8 cycles per transfer
      cycle_limit = 16 + 8 * line_we.size();
      repeat (16) @(posedge clk);
      #2;
      rst_b = 1'b1;
      @(posedge clk);
      #2;
      for (int i = 0; i < line_we.size(); i++) begin
         run_transfer(i);
         // gap 0 keeps the request up, giving back-to-back transfers
         gap = $urandom % 4;
         if (gap != 0) begin
            wb_cyc = 1'b0;
            wb_stb = 1'b0;
            repeat (gap) @(posedge clk);
            #2;
         end
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      // let the last retire slots come due
      while (exp_cycle.size() != 0) @(negedge clk);
      repeat (2) @(negedge clk);
      $display("Testbench passed");
      $finish;
   end

endmodule

//--- tb/mips_assertions.sv
// --------------------------------------------------------------------------
// Wishbone and result port protocol checks, bound into mips_top
// sampled on the rising clock edge
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module mips_assertions (
   input logic clk,
   input logic rst_b,
   input logic wb_cyc,
   input logic wb_stb,
   input logic wb_ack,
   input logic res_valid
);

   // ack only answers a live request
   ack_needs_request: assert property (@(posedge clk) disable iff (!rst_b)
      wb_ack |-> (wb_cyc && wb_stb))
      else $error("wb_ack high without wb_cyc and wb_stb");

   // registered ack is a single-cycle pulse
   ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_b)
      wb_ack |=> !wb_ack)
      else $error("wb_ack high in two consecutive cycles");

   retire_single_cycle: assert property (@(posedge clk) disable iff (!rst_b)
      res_valid |=> !res_valid)
      else $error("res_valid high in two consecutive cycles");

   // outputs stay quiet while reset holds
   quiet_in_reset: assert property (@(posedge clk)
      !rst_b |-> (!wb_ack && !res_valid))
      else $error("wb_ack or res_valid high during reset");

endmodule

bind mips_top mips_assertions u_assertions (
   .clk       (clk),
   .rst_b     (rst_b),
   .wb_cyc    (wb_cyc),
   .wb_stb    (wb_stb),
   .wb_ack    (wb_ack),
   .res_valid (res_valid)
);

//--- hdl/mips_top.sv
// --------------------------------------------------------------------------
// MIPS integer execute path, decode to execute to writeback
// an instruction acked in cycle A retires with res_valid in cycle A+2
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`include "mips_defs.svh"

module mips_top (
   input  logic                       clk,
   input  logic                       rst_b,
   input  logic                       wb_cyc,
   input  logic                       wb_stb,
   input  logic                       wb_we,
   input  logic [`MIPS_REG_BITS-1:0]  wb_adr,
   input  logic [`MIPS_XLEN-1:0]      wb_dat_w,
   output logic [`MIPS_XLEN-1:0]      wb_dat_r,
   output logic                       wb_ack,
   output logic                       res_valid,
   output logic [`MIPS_REG_BITS-1:0]  res_reg,
   output logic [`MIPS_XLEN-1:0]      res_data
);

   // register file read path
   logic [`MIPS_REG_BITS-1:0] rd_addr_a;
   logic [`MIPS_REG_BITS-1:0] rd_addr_b;
   logic [`MIPS_XLEN-1:0]     rd_data_a;
   logic [`MIPS_XLEN-1:0]     rd_data_b;

   mips_stage_if dec_ex ();
   mips_stage_if ex_wb ();

   mips_decode u_decode (
      .clk (clk), .rst_b (rst_b),
      .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
      .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
      .rd_addr_a (rd_addr_a), .rd_addr_b (rd_addr_b),
      .rd_data_a (rd_data_a), .rd_data_b (rd_data_b),
      .ex (dec_ex.src)
   );

   mips_alu u_alu (.clk (clk), .rst_b (rst_b), .dec (dec_ex.dst), .wb (ex_wb.src));

   mips_writeback u_writeback (
      .clk (clk), .rst_b (rst_b), .ex (ex_wb.dst),
      .rd_addr_a (rd_addr_a), .rd_addr_b (rd_addr_b),
      .rd_data_a (rd_data_a), .rd_data_b (rd_data_b),
      .res_valid (res_valid), .res_reg (res_reg), .res_data (res_data)
   );

endmodule

//--- hdl/mips_writeback.sv
// --------------------------------------------------------------------------
// writeback register, 32-entry register file and result port
// register file has two asynchronous read ports and one write port
// res_valid has no ready, the consumer must take every pulse
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`include "mips_defs.svh"

module mips_writeback (
   input  logic                       clk,
   input  logic                       rst_b,
   mips_stage_if.dst                  ex,
   input  logic [`MIPS_REG_BITS-1:0]  rd_addr_a,
   input  logic [`MIPS_REG_BITS-1:0]  rd_addr_b,
   output logic [`MIPS_XLEN-1:0]      rd_data_a,
   output logic [`MIPS_XLEN-1:0]      rd_data_b,
   output logic                       res_valid,
   output logic [`MIPS_REG_BITS-1:0]  res_reg,
   output logic [`MIPS_XLEN-1:0]      res_data
);

   logic [`MIPS_XLEN-1:0] regs [`MIPS_NUM_REGS];

   // regs clear on reset, entry 0 is never written so $0 stays zero
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
         res_valid <= 1'b0;
      end else begin
         res_valid <= ex.valid;
         if (ex.valid && ex.dest != '0) begin
            regs[ex.dest] <= ex.op_a;
         end
      end
   end

   // dest 0 still reports its computed data
   always_ff @(posedge clk) begin
      if (ex.valid) begin
         res_reg  <= ex.dest;
         res_data <= ex.op_a;
      end
   end

   // written on the same edge that raises res_valid
   assign rd_data_a = regs[rd_addr_a];
   assign rd_data_b = regs[rd_addr_b];

endmodule

//--- hdl/mips_alu.sv
// --------------------------------------------------------------------------
// execute register and integer ALU
// result is combinational from the registered operands, one cycle latency
// add and sub wrap, no overflow trap
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`include "mips_defs.svh"

module mips_alu (
   input  logic        clk,
   input  logic        rst_b,
   mips_stage_if.dst   dec,
   mips_stage_if.src   wb
);

   logic                        ex_valid;
   logic [`MIPS_REG_BITS-1:0]   ex_dest;
   mips_pkg::alu_op_t           ex_alu_op;
   logic [`MIPS_XLEN-1:0]       ex_op_a;
   logic [`MIPS_XLEN-1:0]       ex_op_b;
   logic [`MIPS_REG_BITS-1:0]   ex_shamt;
   logic [`MIPS_XLEN-1:0]       result;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         ex_valid <= 1'b0;
      end else begin
         ex_valid <= dec.valid;
      end
   end

   // payload only loads with a new instruction
   always_ff @(posedge clk) begin
      if (dec.valid) begin
         ex_dest   <= dec.dest;
         ex_alu_op <= dec.alu_op;
         ex_op_a   <= dec.op_a;
         ex_op_b   <= dec.op_b;
         ex_shamt  <= dec.shamt;
      end
   end

   always_comb begin
      case (ex_alu_op)
         mips_pkg::ALU_ADD:  result = ex_op_a + ex_op_b;
         mips_pkg::ALU_SUB:  result = ex_op_a - ex_op_b;
         mips_pkg::ALU_AND:  result = ex_op_a & ex_op_b;
         mips_pkg::ALU_OR:   result = ex_op_a | ex_op_b;
         mips_pkg::ALU_XOR:  result = ex_op_a ^ ex_op_b;
         mips_pkg::ALU_NOR:  result = ~(ex_op_a | ex_op_b);
         // set-less-than gives 0 or 1
         mips_pkg::ALU_SLT:  result = {{(`MIPS_XLEN-1){1'b0}}, $signed(ex_op_a) < $signed(ex_op_b)};
         mips_pkg::ALU_SLTU: result = {{(`MIPS_XLEN-1){1'b0}}, ex_op_a < ex_op_b};
         mips_pkg::ALU_SLL:  result = ex_op_a << ex_shamt;
         mips_pkg::ALU_SRL:  result = ex_op_a >> ex_shamt;
         // arithmetic shift fills with the sign bit
         mips_pkg::ALU_SRA:  result = $unsigned($signed(ex_op_a) >>> ex_shamt);
         // immediate moves to the upper half, low half cleared
         mips_pkg::ALU_LUI:  result = {ex_op_b[`MIPS_IMM_BITS-1:0], {`MIPS_IMM_BITS{1'b0}}};
         default:            result = ex_op_a;
      endcase
   end

   // result rides on op_a towards writeback
   assign wb.valid  = ex_valid;
   assign wb.dest   = ex_dest;
   assign wb.alu_op = ex_alu_op;
   assign wb.op_a   = result;
   assign wb.op_b   = ex_op_b;
   assign wb.shamt  = ex_shamt;

endmodule

//--- hdl/mips_decode.sv
// --------------------------------------------------------------------------
// Wishbone classic slave, instruction decode and operand fetch
// ack is registered, so transfers take two cycles and never overlap
// master must hold cyc, stb, we, adr and dat_w until ack
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`include "mips_defs.svh"

module mips_decode (
   input  logic                       clk,
   input  logic                       rst_b,
   input  logic                       wb_cyc,
   input  logic                       wb_stb,
   input  logic                       wb_we,
   input  logic [`MIPS_REG_BITS-1:0]  wb_adr,
   input  logic [`MIPS_XLEN-1:0]      wb_dat_w,
   output logic [`MIPS_XLEN-1:0]      wb_dat_r,
   output logic                       wb_ack,
   output logic [`MIPS_REG_BITS-1:0]  rd_addr_a,
   output logic [`MIPS_REG_BITS-1:0]  rd_addr_b,
   input  logic [`MIPS_XLEN-1:0]      rd_data_a,
   input  logic [`MIPS_XLEN-1:0]      rd_data_b,
   mips_stage_if.src                  ex
);

   mips_pkg::opcode_t           opcode;
   mips_pkg::funct_t            funct;
   mips_pkg::alu_op_t           alu_op;
   logic [`MIPS_REG_BITS-1:0]   rs;
   logic [`MIPS_REG_BITS-1:0]   rt;
   logic [`MIPS_REG_BITS-1:0]   rd;
   logic [`MIPS_REG_BITS-1:0]   shamt;
   logic [`MIPS_IMM_BITS-1:0]   imm;
   logic [`MIPS_XLEN-1:0]       imm_ext;
   logic                        known;
   logic                        r_type;
   logic                        sign_imm;
   logic                        is_shift;
   logic                        var_shift;

   // one-cycle ack pulse, a held request cannot re-ack right away
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= wb_cyc & wb_stb & ~wb_ack;
      end
   end

   // instruction fields, word is stable through the ack cycle
   assign opcode = mips_pkg::opcode_t'(wb_dat_w[`MIPS_OPC_HI:`MIPS_OPC_LO]);
   assign funct  = mips_pkg::funct_t'(wb_dat_w[`MIPS_OPC_HI-`MIPS_OPC_LO:0]);
   assign rs     = wb_dat_w[`MIPS_RS_LO +: `MIPS_REG_BITS];
   assign rt     = wb_dat_w[`MIPS_RT_LO +: `MIPS_REG_BITS];
   assign rd     = wb_dat_w[`MIPS_RD_LO +: `MIPS_REG_BITS];
   assign shamt  = wb_dat_w[`MIPS_SHAMT_LO +: `MIPS_REG_BITS];
   assign imm    = wb_dat_w[`MIPS_IMM_BITS-1:0];

   always_comb begin
      known    = 1'b1;
      r_type   = 1'b0;
      sign_imm = 1'b0;
      alu_op   = mips_pkg::ALU_ADD;
      case (opcode)
         mips_pkg::OP_SPECIAL: begin
            r_type = 1'b1;
            case (funct)
               mips_pkg::FN_ADD, mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
               mips_pkg::FN_SUB, mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
               mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
               mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
               mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
               mips_pkg::FN_NOR:  alu_op = mips_pkg::ALU_NOR;
               mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
               mips_pkg::FN_SLTU: alu_op = mips_pkg::ALU_SLTU;
               mips_pkg::FN_SLL, mips_pkg::FN_SLLV: alu_op = mips_pkg::ALU_SLL;
               mips_pkg::FN_SRL, mips_pkg::FN_SRLV: alu_op = mips_pkg::ALU_SRL;
               mips_pkg::FN_SRA, mips_pkg::FN_SRAV: alu_op = mips_pkg::ALU_SRA;
               default:           known = 1'b0;
            endcase
         end
         // no overflow trap, so addi behaves as addiu
         mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU: begin
            alu_op   = mips_pkg::ALU_ADD;
            sign_imm = 1'b1;
         end
         mips_pkg::OP_SLTI: begin
            alu_op   = mips_pkg::ALU_SLT;
            sign_imm = 1'b1;
         end
         mips_pkg::OP_SLTIU: begin
            alu_op   = mips_pkg::ALU_SLTU;
            sign_imm = 1'b1;
         end
         mips_pkg::OP_ANDI: alu_op = mips_pkg::ALU_AND;
         mips_pkg::OP_ORI:  alu_op = mips_pkg::ALU_OR;
         mips_pkg::OP_XORI: alu_op = mips_pkg::ALU_XOR;
         mips_pkg::OP_LUI:  alu_op = mips_pkg::ALU_LUI;
         default:           known = 1'b0;
      endcase
   end

   assign is_shift  = alu_op inside {mips_pkg::ALU_SLL, mips_pkg::ALU_SRL, mips_pkg::ALU_SRA};
   // funct bit 2 separates sllv/srlv/srav from the fixed forms
   assign var_shift = is_shift & funct[2];
   assign imm_ext   = {{(`MIPS_XLEN-`MIPS_IMM_BITS){sign_imm & imm[`MIPS_IMM_BITS-1]}}, imm};

   // port a reads rs, or the Wishbone address during a read transfer
   assign rd_addr_a = (wb_cyc & wb_stb & ~wb_we) ? wb_adr : rs;
   assign rd_addr_b = rt;
   assign wb_dat_r  = rd_data_a;

   // unknown opcodes are acked but never enter execute
   assign ex.valid  = wb_ack & wb_we & known;
   assign ex.dest   = r_type ? rd : rt;
   assign ex.alu_op = alu_op;
   // shifts move rt into op_a, the ALU always shifts op_a
   assign ex.op_a   = is_shift ? rd_data_b : rd_data_a;
   assign ex.op_b   = is_shift ? rd_data_a : (r_type ? rd_data_b : imm_ext);
   assign ex.shamt  = var_shift ? rd_data_a[`MIPS_REG_BITS-1:0] : shamt;

endmodule

//--- hdl/mips_stage_if.sv
// --------------------------------------------------------------------------
// one instruction moving between pipeline stages
// no handshake, the receiver must take the item in the cycle valid is high
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`include "mips_defs.svh"

interface mips_stage_if;

   logic                       valid;
   // destination register
   logic [`MIPS_REG_BITS-1:0]  dest;
   mips_pkg::alu_op_t          alu_op;
   // operands, op_a carries the result after execute
   logic [`MIPS_XLEN-1:0]      op_a;
   logic [`MIPS_XLEN-1:0]      op_b;
   logic [`MIPS_REG_BITS-1:0]  shamt;

   modport src (output valid, output dest, output alu_op,
                output op_a, output op_b, output shamt);

   modport dst (input valid, input dest, input alu_op,
                input op_a, input op_b, input shamt);

endinterface

//--- hdl/mips_pkg.sv
// --------------------------------------------------------------------------
// opcode, funct and ALU operation encodings
// only the integer ALU subset is listed, anything else decodes as unknown
// --------------------------------------------------------------------------
package mips_pkg;

   // primary opcodes, bits 31:26
   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,
      OP_ADDI    = 6'h08,
      OP_ADDIU   = 6'h09,
      OP_SLTI    = 6'h0a,
      OP_SLTIU   = 6'h0b,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f
   } opcode_t;

   // funct codes under OP_SPECIAL
   // bit 2 set on a shift marks the variable form
   typedef enum logic [5:0] {
      FN_SLL  = 6'h00, FN_SRL  = 6'h02, FN_SRA  = 6'h03,
      FN_SLLV = 6'h04, FN_SRLV = 6'h06, FN_SRAV = 6'h07,
      FN_ADD  = 6'h20, FN_ADDU = 6'h21, FN_SUB  = 6'h22, FN_SUBU = 6'h23,
      FN_AND  = 6'h24, FN_OR   = 6'h25, FN_XOR  = 6'h26, FN_NOR  = 6'h27,
      FN_SLT  = 6'h2a, FN_SLTU = 6'h2b
   } funct_t;

   // execute stage operations
   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB,
      ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
      ALU_SLT, ALU_SLTU,
      ALU_SLL, ALU_SRL, ALU_SRA,
      ALU_LUI
   } alu_op_t;

endpackage

//--- include/mips_defs.svh
// --------------------------------------------------------------------------
// widths and instruction field positions for the MIPS execute path
// field positions follow the MIPS32 R-type and I-type word layout
// MIPS_REG_BITS also sets the shift-amount width (log2 of MIPS_XLEN)
// --------------------------------------------------------------------------
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// data and instruction word width
`define MIPS_XLEN       32
// register number width and register count
`define MIPS_REG_BITS   5
`define MIPS_NUM_REGS   32

// primary opcode field, funct shares its width at the bottom of the word
`define MIPS_OPC_HI     31
`define MIPS_OPC_LO     26
// low bit of each register field
`define MIPS_RS_LO      21
`define MIPS_RT_LO      16
`define MIPS_RD_LO      11
`define MIPS_SHAMT_LO   6
// immediate sits in the low bits
`define MIPS_IMM_BITS   16

`endif
